//--- Makefile
SIM := obj_dir/Vtb_ext_subsys

.PHONY: all run clean

all: run

$(SIM): vlog.f $(wildcard source/*.sv source/*.svh dv/*.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_ext_subsys -f vlog.f

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'TEST PASS'

clean:
	rm -rf obj_dir

//--- dv/ext_subsys_properties.sv
// ------------------------------------------------------------
// concurrent checks on the external subsystem top-level ports
// ------------------------------------------------------------
`timescale 1ns/100ps

`include "xbus_defines.svh"

module ext_subsys_properties (
  input logic              clk_i,
  input logic              arst_n_i,
  input logic              obi_req_i,
  input logic              obi_gnt_o,
  input logic              obi_rvalid_o,
  input obi_pkg::addr_t    obi_addr_i,
  input pwr_pkg::dom_vec_t pwr_switch_n_o,
  input pwr_pkg::dom_vec_t pwr_ack_n_o
);

  int unsigned fail_cnt = 0;
  int unsigned cyc_q;
  int unsigned pend_q;
  logic        accept;
  logic        in_mem;

  assign accept = obi_req_i && obi_gnt_o;
  assign in_mem = obi_addr_i < `XBUS_MEM_WORDS * 4;

  // cycles since reset and responses still owed
  always @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cyc_q  <= 0;
      pend_q <= 0;
    end else begin
      cyc_q  <= cyc_q + 1;
      pend_q <= pend_q + int'(accept) - int'(obi_rvalid_o);
    end
  end

  reset_state: assert property (@(posedge clk_i)
    (!arst_n_i || $rose(arst_n_i)) |-> (!obi_rvalid_o && &pwr_switch_n_o && &pwr_ack_n_o))
    else begin fail_cnt++; $error("bus or switches active in reset"); end

  ack_delay: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (cyc_q > `XBUS_ACK_LATENCY) |-> (pwr_ack_n_o == $past(pwr_switch_n_o, `XBUS_ACK_LATENCY)))
    else begin fail_cnt++; $error("switch acknowledge delay wrong"); end

  no_extra_rvalid: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    obi_rvalid_o |-> (pend_q != 0))
    else begin fail_cnt++; $error("rvalid without an accepted request"); end

  reg_timing: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (accept && !in_mem) |=> obi_rvalid_o)
    else begin fail_cnt++; $error("register or unmapped response late"); end

endmodule

bind ext_subsys_top ext_subsys_properties props (
  .clk_i          (clk_i),
  .arst_n_i       (arst_n_i),
  .obi_req_i      (obi_req_i),
  .obi_gnt_o      (obi_gnt_o),
  .obi_rvalid_o   (obi_rvalid_o),
  .obi_addr_i     (obi_addr_i),
  .pwr_switch_n_o (pwr_switch_n_o),
  .pwr_ack_n_o    (pwr_ack_n_o)
);

//--- dv/tb_ext_subsys.sv
// ------------------------------------------------------------
// testbench for the external subsystem: random bus traffic
// checked against a shadow memory and switch model
// ------------------------------------------------------------
`timescale 1ns/100ps

`include "xbus_defines.svh"

module tb_ext_subsys;

  localparam int unsigned TIMEOUT = 200;
  localparam int unsigned NWORDS  = 16;

  logic              clk_i;
  logic              arst_n_i;
  logic              obi_req_i;
  logic              obi_we_i;
  obi_pkg::be_t      obi_be_i;
  obi_pkg::addr_t    obi_addr_i;
  obi_pkg::data_t    obi_wdata_i;
  logic              obi_gnt_o;
  logic              obi_rvalid_o;
  obi_pkg::data_t    obi_rdata_o;
  pwr_pkg::dom_vec_t pwr_switch_n_o;
  pwr_pkg::dom_vec_t pwr_ack_n_o;

  obi_pkg::data_t    shadow [`XBUS_MEM_WORDS];
  pwr_pkg::dom_vec_t sw_model;
  // switch level after each of the last clock edges with the newest first
  pwr_pkg::dom_vec_t sw_hist [`XBUS_ACK_LATENCY + 1];
  obi_pkg::data_t    exp_q [$];
  logic [11:0]       words [NWORDS];

  ext_subsys_top dut (.*);

  always #2 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i <= `XBUS_ACK_LATENCY; i++) begin
        sw_hist[i] <= '1;
      end
    end else begin
      for (int i = `XBUS_ACK_LATENCY; i > 0; i--) begin
        sw_hist[i] <= sw_hist[i-1];
      end
      sw_hist[0] <= sw_model;
    end
  end

  task automatic stop_on_timeout(input string what);
    $display("TEST FAIL");
    $fatal(1, "timeout: %s", what);
  endtask

  // expected response of one accepted access and the model update
  task automatic predict(input logic we, input obi_pkg::be_t be, input obi_pkg::addr_t addr,
                         input obi_pkg::data_t wdata, output obi_pkg::data_t exp);
    obi_pkg::addr_t poff;
    poff = addr - `XBUS_PWR_BASE;
    exp  = '0;
    if (addr < `XBUS_MEM_WORDS * 4) begin
      if (we) begin
        for (int b = 0; b < 4; b++) begin
          if (be[b]) shadow[addr[13:2]][8*b +: 8] = wdata[8*b +: 8];
        end
      end else begin
        exp = shadow[addr[13:2]];
      end
    end else if (poff < 32'h10) begin
      if (we && poff == 32'h0) begin
        sw_model = wdata[`XBUS_NUM_DOMAINS-1:0];
      end else if (!we && poff == 32'h0) begin
        exp = obi_pkg::data_t'(sw_model);
      end else if (!we && poff == 32'h4) begin
        exp = obi_pkg::data_t'(sw_hist[`XBUS_ACK_LATENCY]);
      end
    end
  endtask

  task automatic issue(input logic we, input obi_pkg::be_t be, input obi_pkg::addr_t addr,
                       input obi_pkg::data_t wdata);
    int unsigned    waited;
    obi_pkg::data_t exp;
    waited = 0;
    @(negedge clk_i);
    obi_req_i   = 1'b1;
    obi_we_i    = we;
    obi_be_i    = be;
    obi_addr_i  = addr;
    obi_wdata_i = wdata;
    #1;
    while (!obi_gnt_o) begin
      waited++;
      if (waited > TIMEOUT) stop_on_timeout("request never granted");
      @(negedge clk_i);
      #1;
    end
    predict(we, be, addr, wdata, exp);
    exp_q.push_back(exp);
    @(posedge clk_i);
  endtask

  task automatic idle();
    @(negedge clk_i);
    obi_req_i = 1'b0;
  endtask

  // waits until every outstanding response has come back
  task automatic drain();
    int unsigned waited;
    waited = 0;
    idle();
    while (exp_q.size() != 0) begin
      waited++;
      if (waited > TIMEOUT) stop_on_timeout("responses missing");
      @(negedge clk_i);
    end
  endtask

  task automatic check_rdata(input obi_pkg::data_t exp);
    assert (obi_rdata_o === exp) else begin
      $display("Fail obi_rdata_o: got %h, expected %h", obi_rdata_o, exp);
      $display("TEST FAIL");
      $fatal(1, "read data mismatch");
    end
  endtask

  // responses come back in request order
  always @(negedge clk_i) begin
    if (arst_n_i && obi_rvalid_o) begin
      if (exp_q.size() == 0) begin
        $display("TEST FAIL");
        $fatal(1, "response seen with no request outstanding");
      end
      check_rdata(exp_q.pop_front());
    end
    if (dut.props.fail_cnt != 0) begin
      $display("TEST FAIL");
      $fatal(1, "a bus or power-switch property failed");
    end
  end

  function automatic obi_pkg::addr_t rand_addr(input int unsigned kind);
    if (kind < 6) return {18'd0, words[$urandom_range(0, NWORDS-1)], 2'b00};
    if (kind < 8) return `XBUS_PWR_BASE + 4 * $urandom_range(0, 3);
    return 32'h0002_0000 + 4 * $urandom_range(0, 255);
  endfunction

  initial begin
    obi_pkg::addr_t a;
    void'($urandom(93803));
    clk_i       = 1'b0;
    arst_n_i    = 1'b1;
    obi_req_i   = 1'b0;
    obi_we_i    = 1'b0;
    obi_be_i    = '0;
    obi_addr_i  = '0;
    obi_wdata_i = '0;
    sw_model    = '1;
    for (int i = 0; i < NWORDS; i++) words[i] = 12'($urandom);
    #1;
    arst_n_i = 1'b0;
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    arst_n_i = 1'b1;

    // full-word fill, then byte-merged writes and read back
    for (int i = 0; i < NWORDS; i++) issue(1'b1, 4'hf, {18'd0, words[i], 2'b00}, $urandom);
    for (int i = 0; i < 40; i++) begin
      issue(1'b1, 4'($urandom), {18'd0, words[$urandom_range(0, NWORDS-1)], 2'b00}, $urandom);
    end
    for (int i = 0; i < NWORDS; i++) issue(1'b0, 4'hf, {18'd0, words[i], 2'b00}, '0);
    drain();

    // switch write, then read back once the acknowledge has settled
    for (int i = 0; i < 4; i++) begin
      issue(1'b1, 4'hf, `XBUS_PWR_BASE, $urandom);
      issue(1'b0, 4'hf, `XBUS_PWR_BASE + 4, '0);
      idle();
      repeat (`XBUS_ACK_LATENCY + 2) @(posedge clk_i);
      issue(1'b0, 4'hf, `XBUS_PWR_BASE, '0);
      issue(1'b0, 4'hf, `XBUS_PWR_BASE + 4, '0);
      drain();
    end

    // back-to-back mixed traffic over all targets
    for (int i = 0; i < 300; i++) begin
      a = rand_addr($urandom_range(0, 9));
      issue(1'($urandom), 4'($urandom), a, $urandom);
    end
    drain();
    for (int i = 0; i < NWORDS; i++) issue(1'b0, 4'hf, {18'd0, words[i], 2'b00}, '0);
    issue(1'b0, 4'hf, `XBUS_PWR_BASE, '0);
    drain();

    if (dut.props.fail_cnt != 0) begin
      $display("TEST FAIL");
      $fatal(1, "a bus or power-switch property failed");
    end else begin
      $display("TEST PASS");
      $finish;
    end
  end

endmodule

//--- source/ext_bus_demux.sv
// ------------------------------------------------------------
// external bus demux: address decode, in-order grant gating
// and response merge for memory, power registers and holes
// ------------------------------------------------------------
`timescale 1ns/100ps

`include "xbus_defines.svh"

module ext_bus_demux (
  input  logic           clk_i,
  input  logic           arst_n_i,
  input  logic           req_i,
  input  logic           we_i,
  input  obi_pkg::be_t   be_i,
  input  obi_pkg::addr_t addr_i,
  input  obi_pkg::data_t wdata_i,
  output logic           gnt_o,
  output logic           rvalid_o,
  output obi_pkg::data_t rdata_o,
  obi_if.manager         mem_bus,
  obi_if.manager         pwr_bus
);

  // enough room for a full FIFO plus the read stage behind it
  localparam int unsigned CNT_W = $clog2(`XBUS_FIFO_DEPTH + 2) + 1;

  obi_pkg::tgt_e    tgt;
  obi_pkg::tgt_e    out_tgt_q;
  logic [CNT_W-1:0] out_cnt_q;
  obi_pkg::addr_t   mem_off;
  obi_pkg::addr_t   pwr_off;
  logic             may_issue;
  logic             sel_gnt;
  logic             accept;
  logic             none_rvalid_q;

  // window offsets wrap below the base, so one compare covers both bounds
  assign mem_off = addr_i - `XBUS_MEM_BASE;
  assign pwr_off = addr_i - `XBUS_PWR_BASE;

  always_comb begin
    if (mem_off < (`XBUS_MEM_WORDS * 32'd4)) begin
      tgt = obi_pkg::TGT_MEM;
    end else if (pwr_off < `XBUS_PWR_SIZE) begin
      tgt = obi_pkg::TGT_PWR;
    end else begin
      tgt = obi_pkg::TGT_NONE;
    end
  end

  // only stack up requests behind responses from the same target
  assign may_issue = (out_cnt_q == '0) || (out_tgt_q == tgt);

  always_comb begin
    case (tgt)
      obi_pkg::TGT_MEM: sel_gnt = mem_bus.gnt;
      obi_pkg::TGT_PWR: sel_gnt = pwr_bus.gnt;
      default:          sel_gnt = 1'b1;
    endcase
  end

  assign gnt_o  = req_i && may_issue && sel_gnt;
  assign accept = gnt_o;

  // request fan-out, req itself is steered and gated
  assign mem_bus.req   = req_i && may_issue && (tgt == obi_pkg::TGT_MEM);
  assign mem_bus.we    = we_i;
  assign mem_bus.be    = be_i;
  assign mem_bus.addr  = addr_i;
  assign mem_bus.wdata = wdata_i;

  assign pwr_bus.req   = req_i && may_issue && (tgt == obi_pkg::TGT_PWR);
  assign pwr_bus.we    = we_i;
  assign pwr_bus.be    = be_i;
  assign pwr_bus.addr  = addr_i;
  assign pwr_bus.wdata = wdata_i;

  // at most one source is valid per cycle thanks to the grant gating
  assign rvalid_o = mem_bus.rvalid | pwr_bus.rvalid | none_rvalid_q;

  always_comb begin
    if (mem_bus.rvalid) begin
      rdata_o = mem_bus.rdata;
    end else if (pwr_bus.rvalid) begin
      rdata_o = pwr_bus.rdata;
    end else begin
      rdata_o = '0;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      out_cnt_q     <= '0;
      out_tgt_q     <= obi_pkg::TGT_NONE;
      none_rvalid_q <= 1'b0;
    end else begin
      // unmapped access answers itself one cycle later with zero
      none_rvalid_q <= accept && (tgt == obi_pkg::TGT_NONE);
      if (accept) begin
        out_tgt_q <= tgt;
      end
      unique case ({accept, rvalid_o})
        2'b10:   out_cnt_q <= out_cnt_q + 1'b1;
        2'b01:   out_cnt_q <= out_cnt_q - 1'b1;
        default: out_cnt_q <= out_cnt_q;
      endcase
    end
  end

endmodule

//--- source/ext_subsys_top.sv
// ------------------------------------------------------------
// external subsystem top: bus demux, slow memory and
// power-switch emulation
// ------------------------------------------------------------
`timescale 1ns/100ps

module ext_subsys_top (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  logic              obi_req_i,
  input  logic              obi_we_i,
  input  obi_pkg::be_t      obi_be_i,
  input  obi_pkg::addr_t    obi_addr_i,
  input  obi_pkg::data_t    obi_wdata_i,
  output logic              obi_gnt_o,
  output logic              obi_rvalid_o,
  output obi_pkg::data_t    obi_rdata_o,
  output pwr_pkg::dom_vec_t pwr_switch_n_o,
  output pwr_pkg::dom_vec_t pwr_ack_n_o
);

  obi_if mem_bus ();
  obi_if pwr_bus ();

  ext_bus_demux ext_bus_demux_i (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .req_i    (obi_req_i),
    .we_i     (obi_we_i),
    .be_i     (obi_be_i),
    .addr_i   (obi_addr_i),
    .wdata_i  (obi_wdata_i),
    .gnt_o    (obi_gnt_o),
    .rvalid_o (obi_rvalid_o),
    .rdata_o  (obi_rdata_o),
    .mem_bus  (mem_bus),
    .pwr_bus  (pwr_bus)
  );

  slow_mem slow_mem_i (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .bus      (mem_bus)
  );

  pwr_switch_ctrl pwr_switch_ctrl_i (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .bus        (pwr_bus),
    .switch_n_o (pwr_switch_n_o),
    .ack_n_o    (pwr_ack_n_o)
  );

endmodule

//--- source/obi_if.sv
// ------------------------------------------------------------
// request/grant/rvalid bus between the demux and a subordinate
// ------------------------------------------------------------
`timescale 1ns/100ps

interface obi_if;

  // request channel
  logic           req;
  logic           we;
  obi_pkg::be_t   be;
  obi_pkg::addr_t addr;
  obi_pkg::data_t wdata;

  // grant and response channel
  logic           gnt;
  logic           rvalid;
  obi_pkg::data_t rdata;

  modport manager (
    output req, we, be, addr, wdata,
    input  gnt, rvalid, rdata
  );

  modport subordinate (
    input  req, we, be, addr, wdata,
    output gnt, rvalid, rdata
  );

endinterface

//--- source/obi_pkg.sv
// ------------------------------------------------------------
// bus types for the external request/grant/rvalid bus
// ------------------------------------------------------------
package obi_pkg;

  // byte address and data word
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;

  // one enable per byte lane
  typedef logic [3:0] be_t;

  // decoded subordinate of a request
  typedef enum logic [1:0] {
    TGT_MEM  = 2'd0,
    TGT_PWR  = 2'd1,
    TGT_NONE = 2'd2
  } tgt_e;

endpackage

//--- source/pwr_pkg.sv
// ------------------------------------------------------------
// power-domain vector and switch register offsets
// ------------------------------------------------------------
`include "xbus_defines.svh"

package pwr_pkg;

  // one active-low bit per domain, 1 means switched off
  typedef logic [`XBUS_NUM_DOMAINS-1:0] dom_vec_t;

  // byte offsets within the power register window
  typedef enum logic [31:0] {
    PWR_SWITCH = 32'h0000_0000,
    PWR_ACK    = 32'h0000_0004
  } pwr_reg_e;

endpackage

//--- source/pwr_switch_ctrl.sv
// ------------------------------------------------------------
// power-switch register block with emulated switch-cell
// acknowledge delay
// ------------------------------------------------------------
`timescale 1ns/100ps

`include "xbus_defines.svh"

module pwr_switch_ctrl (
  input  logic              clk_i,
  input  logic              arst_n_i,
  obi_if.subordinate        bus,
  output pwr_pkg::dom_vec_t switch_n_o,
  output pwr_pkg::dom_vec_t ack_n_o
);

  localparam int unsigned LAT = `XBUS_ACK_LATENCY;

  pwr_pkg::dom_vec_t switch_q;
  pwr_pkg::dom_vec_t dly_q [LAT];
  obi_pkg::addr_t    offset;
  logic              accept;
  logic              rvalid_q;
  obi_pkg::data_t    rdata_q;

  // register accesses never stall
  assign bus.gnt    = 1'b1;
  assign accept     = bus.req;
  assign offset     = bus.addr - `XBUS_PWR_BASE;
  assign bus.rvalid = rvalid_q;
  assign bus.rdata  = rdata_q;

  assign switch_n_o = switch_q;
  assign ack_n_o    = dly_q[LAT-1];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      // every domain starts switched off
      switch_q <= '1;
      rvalid_q <= 1'b0;
      for (int i = 0; i < LAT; i++) begin
        dly_q[i] <= '1;
      end
    end else begin
      rvalid_q <= accept;
      if (accept && bus.we && (offset == pwr_pkg::PWR_SWITCH)) begin
        switch_q <= bus.wdata[`XBUS_NUM_DOMAINS-1:0];
      end
      // switch cells answer LAT cycles after the request level
      dly_q[0] <= switch_q;
      for (int i = 1; i < LAT; i++) begin
        dly_q[i] <= dly_q[i-1];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      if (bus.we) begin
        rdata_q <= '0;
      end else begin
        case (offset)
          pwr_pkg::PWR_SWITCH: rdata_q <= obi_pkg::data_t'(switch_q);
          pwr_pkg::PWR_ACK:    rdata_q <= obi_pkg::data_t'(dly_q[LAT-1]);
          default:             rdata_q <= '0;
        endcase
      end
    end
  end

endmodule

//--- source/slow_mem.sv
// ------------------------------------------------------------
// slow external memory: latency FIFO with random pop stalls
// in front of a byte-enabled word array
// ------------------------------------------------------------
`timescale 1ns/100ps

`include "xbus_defines.svh"

module slow_mem (
  input logic        clk_i,
  input logic        arst_n_i,
  obi_if.subordinate bus
);

  localparam int unsigned DEPTH = `XBUS_FIFO_DEPTH;
  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);
  localparam int unsigned IDX_W = $clog2(`XBUS_MEM_WORDS);

  typedef struct packed {
    logic             we;
    obi_pkg::be_t     be;
    logic [IDX_W-1:0] idx;
    obi_pkg::data_t   wdata;
  } entry_t;

  entry_t           fifo_q [DEPTH];
  entry_t           head;
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] cnt_q;
  logic             full;
  logic             empty;
  logic             push;
  logic             pop;
  logic [7:0]       lfsr_q;
  obi_pkg::addr_t   offset;
  obi_pkg::data_t   mem_q [`XBUS_MEM_WORDS];
  logic             rvalid_q;
  obi_pkg::data_t   rdata_q;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign offset = bus.addr - `XBUS_MEM_BASE;
  assign full   = (cnt_q == CNT_W'(DEPTH));
  assign empty  = (cnt_q == '0);
  assign push   = bus.req && !full;
  // roughly one pop in four is held back to model a slow device
  assign pop    = !empty && (lfsr_q[1:0] != 2'b00);
  assign head   = fifo_q[rd_ptr_q];

  assign bus.gnt    = !full;
  assign bus.rvalid = rvalid_q;
  assign bus.rdata  = rdata_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
      lfsr_q   <= 8'hA5;
      rvalid_q <= 1'b0;
    end else begin
      // x^8 + x^6 + x^5 + x^4 + 1
      lfsr_q   <= {lfsr_q[6:0], lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3]};
      rvalid_q <= pop;
      if (push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      unique case ({push, pop})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      fifo_q[wr_ptr_q] <= '{we: bus.we, be: bus.be, idx: offset[IDX_W+1:2], wdata: bus.wdata};
    end
  end

  // word array, one access per popped entry
  always_ff @(posedge clk_i) begin
    if (pop) begin
      if (head.we) begin
        for (int b = 0; b < 4; b++) begin
          if (head.be[b]) begin
            mem_q[head.idx][8*b +: 8] <= head.wdata[8*b +: 8];
          end
        end
        rdata_q <= '0;
      end else begin
        rdata_q <= mem_q[head.idx];
      end
    end
  end

endmodule

//--- source/xbus_defines.svh
// ------------------------------------------------------------
// external bus address map, memory size and power-switch timing
// ------------------------------------------------------------
`ifndef XBUS_DEFINES_SVH
`define XBUS_DEFINES_SVH

// slow memory window, size in 32-bit words
`define XBUS_MEM_BASE 32'h0000_0000
`define XBUS_MEM_WORDS 32'd4096

// power-switch register window
`define XBUS_PWR_BASE 32'h0001_0000
`define XBUS_PWR_SIZE 32'h0000_0010

// extra latency FIFO in front of the memory
`define XBUS_FIFO_DEPTH 32'd2

// switchable domains and emulated switch-cell delay in cycles
`define XBUS_NUM_DOMAINS 32'd4
`define XBUS_ACK_LATENCY 32'd15

`endif

//--- vlog.f
+incdir+source
source/obi_pkg.sv
source/pwr_pkg.sv
source/obi_if.sv
source/ext_bus_demux.sv
source/slow_mem.sv
source/pwr_switch_ctrl.sv
source/ext_subsys_top.sv
dv/ext_subsys_properties.sv
dv/tb_ext_subsys.sv
